// ==== tb.f ====
firCfgPkg.sv
firCoefPkg.sv
rateEnableGen.sv
sampleWindow.sv
daLutUnit.sv
staggerSerializer.sv
outputFormatter.sv
firStaggeredTop.sv
tbFir.sv

// ==== runSim.sh ====
#!/bin/sh
# Verilator build and run of the FIR testbench
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --top-module tbFir -f tb.f -o simFir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simFir > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// ==== tbFir.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbFir;

    import firCfgPkg::*;
    import firCoefPkg::*;

    localparam int resetCycles = 10;
    localparam int lenOnes = 200;
    localparam int lenZeros = 200;
    localparam int lenAlt = 240;
    localparam int lenRandom = 480;
    localparam int lenSlow = 320;
    localparam int lenRestart = 240;
    localparam int stimCycles = lenOnes + lenZeros + lenAlt + lenRandom + lenSlow + lenRestart
                                + 6 * (resetCycles + 2);
    localparam int timeoutLimit = 3 * stimCycles + 200;
    // Longer than three output periods
    localparam int ackHoldCycles = 4 * dsr;
    // Keeps outReq high for a few cycles before the ack
    localparam int ackDelayCycles = 2;
    localparam int maxSamples = 512;
    localparam int satMax = 2 ** (outWidth - 1) - 1;
    localparam int satMin = -(2 ** (outWidth - 1));
    localparam int kindOnes = 0;
    localparam int kindZeros = 1;
    localparam int kindAlt = 2;
    localparam int kindRandom = 3;

    logic                clkOut;
    logic                rst;
    logic                inBit;
    logic                outAck;
    logic [outWidth-1:0] outData;
    logic                outReq;
    logic                overrun;

    bit                  samples [maxSamples];
    logic [15:0]         lfsrState;
    int                  coefSum;
    int                  dataErrs = 0;
    int                  flagErrs = 0;
    int                  otherErrs = 0;
    int                  wordCount = 0;
    int                  wordIndex = 0;
    int                  firstReqCycle = 0;
    int                  holdLeft = 0;
    int                  waitLeft = ackDelayCycles;
    int                  cycleCount;
    logic                consumerOn = 1'b0;
    logic                slowAck = 1'b0;
    logic                constCheck = 1'b0;
    logic [outWidth-1:0] constWord = '0;
    logic                prevReq;
    logic                prevAck;
    logic [outWidth-1:0] prevData;

    firStaggeredTop DUT (
        .clkOut(clkOut), .rst(rst), .inBit(inBit), .outAck(outAck),
        .outData(outData), .outReq(outReq), .overrun(overrun)
    );

    initial begin
        clkOut = 1'b0;
        forever #4 clkOut = ~clkOut;
    end

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    function automatic bit nextBit(input int kind, input int n);
        if (kind == kindOnes) begin
            return 1'b1;
        end else if (kind == kindZeros) begin
            return 1'b0;
        end else if (kind == kindAlt) begin
            return (n % 2) == 0;
        end
        lfsrState = lfsrNext(lfsrState);
        return lfsrState[0];
    endfunction

    // Shift, clip to 12 bits, flip the sign for offset binary
    function automatic logic [outWidth-1:0] formatWord(input int acc);
        int scaled;
        logic [outWidth-1:0] word;
        scaled = acc >>> outShift;
        if (scaled > satMax) begin
            scaled = satMax;
        end else if (scaled < satMin) begin
            scaled = satMin;
        end
        word = outWidth'(scaled);
        word[outWidth-1] = ~word[outWidth-1];
        return word;
    endfunction

    // Tap j of window k weights sample 8k + 7 - j with bit 1 as +1 and bit 0 as -1
    function automatic logic [outWidth-1:0] firModel(input int k);
        int acc;
        int idx;
        acc = 0;
        for (int j = 0; j < lookahead + lookback; j++) begin
            idx = dsr * k + dsr - 1 - j;
            if (idx >= 0 && samples[idx]) begin
                acc = acc + int'(coef[j]);
            end else begin
                acc = acc - int'(coef[j]);
            end
        end
        return formatWord(acc);
    endfunction

    task automatic checkOutData(input string sigName, input logic [outWidth-1:0] got,
                                input logic [outWidth-1:0] exp);
        if (got !== exp) begin
            dataErrs++;
            $display("mismatch %s got 0x%h expected 0x%h at %0t", sigName, got, exp, $time);
        end
    endtask

    task automatic checkOverrun(input logic got, input logic exp);
        if (got !== exp) begin
            flagErrs++;
            $display("mismatch overrun got 0x%h expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic printSummary();
        $display("errors: data %0d, flag %0d, other %0d", dataErrs, flagErrs, otherErrs);
    endtask

    task automatic applyReset(input int kind, input bit slow);
        @(posedge clkOut);
        consumerOn = 1'b0;
        #1;
        rst = 1'b0;
        inBit = 1'b0;
        slowAck = slow;
        constCheck = (kind == kindOnes) || (kind == kindZeros);
        constWord = formatWord((kind == kindOnes) ? coefSum : -coefSum);
        repeat (resetCycles) @(posedge clkOut);
        consumerOn = 1'b1;
        #1;
        if (outReq !== 1'b0) begin
            otherErrs++;
            $display("outReq is still high after reset at %0t", $time);
        end
        checkOverrun(overrun, 1'b0);
        checkOutData("outData", outData, '0);
    endtask

    task automatic runPhase(input int kind, input int nCycles, input bit slow);
        bit b;
        int words;
        applyReset(kind, slow);
        for (int n = 0; n < nCycles; n++) begin
            if (n > 0) begin
                @(posedge clkOut);
                #1;
            end else begin
                rst = 1'b1;
            end
            b = nextBit(kind, n);
            samples[n] = b;
            inBit = b;
        end
        @(posedge clkOut);
        words = wordCount;
        #1;
        checkOverrun(overrun, slow);
        if ((!slow && words < nCycles / dsr - 16) || (slow && words < 2)) begin
            otherErrs++;
            $display("only %0d output words arrived in a %0d cycle phase", words, nCycles);
        end
    endtask

    // Four-phase consumer that acks a little late and may hold outAck
    initial begin
        outAck = 1'b0;
        forever begin
            @(posedge clkOut);
            #1;
            if (!consumerOn) begin
                outAck = 1'b0;
                holdLeft = 0;
                waitLeft = ackDelayCycles;
                wordCount = 0;
            end else if (!outAck) begin
                if (outReq && waitLeft == ackDelayCycles) begin
                    // Dropped words still use up their output period
                    if (wordCount == 0) begin
                        firstReqCycle = cycleCount;
                    end
                    wordIndex = slowAck ? (cycleCount - firstReqCycle) / dsr : wordCount;
                end
                if (outReq && waitLeft > 0) begin
                    waitLeft--;
                end else if (outReq) begin
                    checkOutData("outData", outData, firModel(wordIndex + validCount - 1));
                    if (constCheck) begin
                        checkOutData("outData", outData, constWord);
                    end
                    checkOverrun(overrun, slowAck && (wordCount > 0));
                    wordCount++;
                    outAck = 1'b1;
                    holdLeft = slowAck ? ackHoldCycles : 0;
                    waitLeft = ackDelayCycles;
                end
            end else if (holdLeft > 0) begin
                holdLeft--;
                if (holdLeft == 0) begin
                    checkOverrun(overrun, 1'b1);
                end
            end else if (!outReq) begin
                outAck = 1'b0;
            end
        end
    end

    // Handshake rules checked mid-cycle
    initial begin
        prevReq = 1'b0;
        prevAck = 1'b0;
        prevData = '0;
        forever begin
            @(negedge clkOut);
            if (outReq && !prevReq && prevAck) begin
                otherErrs++;
                $display("outReq rose while outAck was still high at %0t", $time);
            end
            if (outReq && prevReq) begin
                checkOutData("outData held", outData, prevData);
            end
            prevReq = outReq;
            prevAck = outAck;
            prevData = outData;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutLimit) begin
            @(posedge clkOut);
            cycleCount++;
        end
        $display("timeout after %0d cycles before the tests finished", cycleCount);
        printSummary();
        $display("sim failed");
        $finish;
    end

    initial begin
        rst = 1'b0;
        inBit = 1'b0;
        lfsrState = 16'd7;
        coefSum = 0;
        for (int j = 0; j < lookahead + lookback; j++) begin
            coefSum = coefSum + int'(coef[j]);
        end
        runPhase(kindOnes, lenOnes, 1'b0);
        runPhase(kindZeros, lenZeros, 1'b0);
        runPhase(kindAlt, lenAlt, 1'b0);
        runPhase(kindRandom, lenRandom, 1'b0);
        runPhase(kindRandom, lenSlow, 1'b1);
        // Restart after the overrun phase
        runPhase(kindRandom, lenRestart, 1'b0);
        printSummary();
        if (dataErrs + flagErrs + otherErrs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== firStaggeredTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module firStaggeredTop (
    input  wire                            clkOut,
    input  wire                            rst,
    input  wire                            inBit,
    input  wire                            outAck,
    output logic [firCfgPkg::outWidth-1:0] outData,
    output logic                           outReq,
    output logic                           overrun
);

    import firCfgPkg::*;

    logic                       evalEn;
    logic                       phaseEn;
    logic [lookahead-1:0]       aheadWin0;
    logic [lookahead-1:0]       aheadWin1;
    logic [lookback-1:0]        backWin0;
    logic [lookback-1:0]        backWin1;
    logic signed [accWidth-1:0] aheadSum0;
    logic signed [accWidth-1:0] backSum0;
    logic signed [accWidth-1:0] aheadSum1;
    logic signed [accWidth-1:0] backSum1;
    logic                       resValid;
    logic signed [accWidth-1:0] result;

    rateEnableGen rateGen (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .phaseEn(phaseEn)
    );

    sampleWindow window (
        .clkOut(clkOut), .rst(rst), .inBit(inBit), .evalEn(evalEn),
        .aheadWin0(aheadWin0), .aheadWin1(aheadWin1),
        .backWin0(backWin0), .backWin1(backWin1)
    );

    // Two units per stagger copy
    daLutUnit #(.isAhead(1'b1)) aheadLut0 (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .window(aheadWin0), .partSum(aheadSum0)
    );
    daLutUnit #(.isAhead(1'b0)) backLut0 (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .window(backWin0), .partSum(backSum0)
    );
    daLutUnit #(.isAhead(1'b1)) aheadLut1 (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .window(aheadWin1), .partSum(aheadSum1)
    );
    daLutUnit #(.isAhead(1'b0)) backLut1 (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .window(backWin1), .partSum(backSum1)
    );

    staggerSerializer serializer (
        .clkOut(clkOut), .rst(rst), .evalEn(evalEn), .phaseEn(phaseEn),
        .aheadSum0(aheadSum0), .backSum0(backSum0),
        .aheadSum1(aheadSum1), .backSum1(backSum1),
        .resValid(resValid), .result(result)
    );

    outputFormatter formatter (
        .clkOut(clkOut), .rst(rst), .resValid(resValid), .result(result),
        .outAck(outAck), .outData(outData), .outReq(outReq), .overrun(overrun)
    );

endmodule

`default_nettype wire

// ==== outputFormatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputFormatter (
    input  wire                                  clkOut,
    input  wire                                  rst,
    input  wire                                  resValid,
    input  wire signed [firCfgPkg::accWidth-1:0] result,
    input  wire                                  outAck,
    output logic [firCfgPkg::outWidth-1:0]       outData,
    output logic                                 outReq,
    output logic                                 overrun
);

    import firCfgPkg::*;

    logic signed [scaledWidth-1:0] scaled;
    logic [satHeadBits-1:0]        headBits;
    logic [outWidth-1:0]           saturated;
    logic [outWidth-1:0]           formatted;
    logic                          accept;

    // Arithmetic shift right by dropping the low bits
    assign scaled = result[accWidth-1:outShift];
    assign headBits = scaled[scaledWidth-1:outWidth-1];

    // Clip when the bits above the output sign disagree
    always_comb begin
        if ((headBits == '0) || (headBits == '1)) begin
            saturated = scaled[outWidth-1:0];
        end else if (scaled[scaledWidth-1]) begin
            saturated = {1'b1, {(outWidth-1){1'b0}}};
        end else begin
            saturated = {1'b0, {(outWidth-1){1'b1}}};
        end
    end

    // Offset binary
    assign formatted = {~saturated[outWidth-1], saturated[outWidth-2:0]};

    // Only an idle handshake with outAck back low takes a new word
    assign accept = resValid && !outReq && !outAck;

    always_ff @(posedge clkOut) begin
        if (!rst) begin
            outData <= '0;
            outReq <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (accept) begin
                outData <= formatted;
                outReq <= 1'b1;
            end else if (outReq && outAck) begin
                outReq <= 1'b0;
            end
            // Sticky until the next reset
            if (resValid && !accept) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== staggerSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module staggerSerializer (
    input  wire                                   clkOut,
    input  wire                                   rst,
    input  wire                                   evalEn,
    input  wire                                   phaseEn,
    input  wire signed [firCfgPkg::accWidth-1:0]  aheadSum0,
    input  wire signed [firCfgPkg::accWidth-1:0]  backSum0,
    input  wire signed [firCfgPkg::accWidth-1:0]  aheadSum1,
    input  wire signed [firCfgPkg::accWidth-1:0]  backSum1,
    output logic                                  resValid,
    output logic signed [firCfgPkg::accWidth-1:0] result
);

    import firCfgPkg::*;

    logic signed [accWidth-1:0] totResult   [stagger];
    logic signed [accWidth-1:0] resultShift [stagger];
    logic                       loadPending;
    logic [warmWidth-1:0]       warmCnt;

    // Final adder per stagger copy
    always_ff @(posedge clkOut) begin
        if (evalEn) begin
            totResult[0] <= aheadSum0 + backSum0;
            totResult[1] <= aheadSum1 + backSum1;
        end
    end

    // Load on the first phase after an evaluation, shift on the others
    always_ff @(posedge clkOut) begin
        if (phaseEn) begin
            if (loadPending) begin
                for (int j = 0; j < stagger; j++) begin
                    resultShift[j] <= totResult[j];
                end
            end else begin
                for (int j = 0; j < stagger - 1; j++) begin
                    resultShift[j] <= resultShift[j+1];
                end
                resultShift[stagger-1] <= '0;
            end
        end
    end

    assign result = resultShift[0];

    // Phases before the pipeline and the first full window are dropped
    always_ff @(posedge clkOut) begin
        if (!rst) begin
            loadPending <= 1'b0;
            warmCnt <= '0;
            resValid <= 1'b0;
        end else begin
            if (evalEn) begin
                loadPending <= 1'b1;
            end else if (phaseEn) begin
                loadPending <= 1'b0;
            end
            resValid <= phaseEn && (warmCnt == warmWidth'(warmPhases));
            if (phaseEn && (warmCnt != warmWidth'(warmPhases))) begin
                warmCnt <= warmCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== daLutUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module daLutUnit #(
    parameter bit isAhead = 1'b1
) (
    input  wire                                   clkOut,
    input  wire                                   rst,
    input  wire                                   evalEn,
    input  wire        [firCfgPkg::lookahead-1:0] window,
    output logic signed [firCfgPkg::accWidth-1:0] partSum
);

    import firCfgPkg::*;
    import firCoefPkg::*;

    logic signed [accWidth-1:0] lutRead [lutsPerUnit];
    logic signed [accWidth-1:0] lutReg  [lutsPerUnit];
    logic signed [accWidth-1:0] treeSum;

    // Each 4-bit slice of the window addresses its own table
    always_comb begin
        for (int g = 0; g < lutsPerUnit; g++) begin
            if (isAhead) begin
                lutRead[g] = lutAhead[g][window[g*lutSize +: lutSize]];
            end else begin
                lutRead[g] = lutBack[g][window[g*lutSize +: lutSize]];
            end
        end
    end

    // Adder tree over the registered table outputs
    always_comb begin
        treeSum = '0;
        for (int g = 0; g < lutsPerUnit; g++) begin
            treeSum = treeSum + lutReg[g];
        end
    end

    // Two evaluation periods of latency, table read then tree
    always_ff @(posedge clkOut) begin
        if (!rst) begin
            for (int g = 0; g < lutsPerUnit; g++) begin
                lutReg[g] <= '0;
            end
            partSum <= '0;
        end else if (evalEn) begin
            for (int g = 0; g < lutsPerUnit; g++) begin
                lutReg[g] <= lutRead[g];
            end
            partSum <= treeSum;
        end
    end

endmodule

`default_nettype wire

// ==== sampleWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleWindow (
    input  wire                              clkOut,
    input  wire                              rst,
    input  wire                              inBit,
    input  wire                              evalEn,
    output logic [firCfgPkg::lookahead-1:0]  aheadWin0,
    output logic [firCfgPkg::lookahead-1:0]  aheadWin1,
    output logic [firCfgPkg::lookback-1:0]   backWin0,
    output logic [firCfgPkg::lookback-1:0]   backWin1
);

    import firCfgPkg::*;

    logic [staggerWidth-1:0] stageBits;
    logic [lookTotal-1:0]    history;
    logic [aheadSpan-1:0]    aheadAll;
    logic [backSpan-1:0]     backAll;

    // Newest sample always sits at bit 0
    always_ff @(posedge clkOut) begin
        if (!rst) begin
            stageBits <= '0;
            history <= '0;
        end else begin
            stageBits <= {stageBits[staggerWidth-2:0], inBit};
            if (evalEn) begin
                history <= {history[lookTotal-staggerWidth-1:0], stageBits};
            end
        end
    end

    // Lookahead part reversed so bit 0 is the sample next to the center
    always_comb begin
        for (int i = 0; i < aheadSpan; i++) begin
            aheadAll[i] = history[aheadSpan-1-i];
        end
    end

    assign backAll = history[lookTotal-1:lookahead];

    // Copy 1 is dsr samples newer than copy 0
    assign aheadWin0 = aheadAll[0 +: lookahead];
    assign aheadWin1 = aheadAll[dsr +: lookahead];
    assign backWin0 = backAll[dsr +: lookback];
    assign backWin1 = backAll[0 +: lookback];

endmodule

`default_nettype wire

// ==== rateEnableGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rateEnableGen (
    input  wire  clkOut,
    input  wire  rst,
    output logic evalEn,
    output logic phaseEn
);

    import firCfgPkg::*;

    logic [cntWidth-1:0] phaseCnt;

    // One count drives both rates so the enables stay phase-aligned
    always_ff @(posedge clkOut) begin
        if (!rst) begin
            phaseCnt <= '0;
            evalEn <= 1'b0;
            phaseEn <= 1'b0;
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
            // Evaluation once the staging register holds a full group
            evalEn <= (phaseCnt == cntWidth'(evalPeriod - 1));
            // Output phase every dsr samples
            phaseEn <= (phaseCnt[phaseWidth-1:0] == phaseWidth'(dsr - 1));
        end
    end

endmodule

`default_nettype wire

// ==== firCoefPkg.sv ====
`default_nettype none

package firCoefPkg;

    import firCfgPkg::*;

    // Symmetric lowpass in Q0.14, tap 0 weights the newest sample
    localparam logic signed [coefWidth-1:0] coef [lookahead + lookback] = '{
        -15'sd70,   -15'sd180,  15'sd150,   15'sd700,
        15'sd1350,  15'sd1850,  15'sd2050,  15'sd2150,
        15'sd2150,  15'sd2050,  15'sd1850,  15'sd1350,
        15'sd700,   15'sd150,   -15'sd180,  -15'sd70
    };

    // Entry = sum of +coef for a set address bit and -coef for a clear one
    // Lookahead LUT g, address bit t weights coef[7 - 4g - t]
    localparam logic signed [accWidth-1:0] lutAhead [lutsPerUnit][lutEntries] = '{
        '{-18'sd7400, -18'sd3100, -18'sd3300, 18'sd1000,
          -18'sd3700, 18'sd600,   18'sd400,   18'sd4700,
          -18'sd4700, -18'sd400,  -18'sd600,  18'sd3700,
          -18'sd1000, 18'sd3300,  18'sd3100,  18'sd7400},
        '{-18'sd600,  18'sd800,   -18'sd300,  18'sd1100,
          -18'sd960,  18'sd440,   -18'sd660,  18'sd740,
          -18'sd740,  18'sd660,   -18'sd440,  18'sd960,
          -18'sd1100, 18'sd300,   -18'sd800,  18'sd600}
    };

    // Lookback LUT g, address bit t weights coef[8 + 4g + t]
    // Matches lutAhead only because the taps are mirrored
    localparam logic signed [accWidth-1:0] lutBack [lutsPerUnit][lutEntries] = '{
        '{-18'sd7400, -18'sd3100, -18'sd3300, 18'sd1000,
          -18'sd3700, 18'sd600,   18'sd400,   18'sd4700,
          -18'sd4700, -18'sd400,  -18'sd600,  18'sd3700,
          -18'sd1000, 18'sd3300,  18'sd3100,  18'sd7400},
        '{-18'sd600,  18'sd800,   -18'sd300,  18'sd1100,
          -18'sd960,  18'sd440,   -18'sd660,  18'sd740,
          -18'sd740,  18'sd660,   -18'sd440,  18'sd960,
          -18'sd1100, 18'sd300,   -18'sd800,  18'sd600}
    };

endpackage

`default_nettype wire

// ==== firCfgPkg.sv ====
`default_nettype none

package firCfgPkg;

    // Modulator and filter geometry
    localparam int sampleBits = 1;
    localparam int dsr = 8;
    localparam int stagger = 2;
    localparam int lookahead = 8;
    localparam int lookback = 8;
    localparam int lookTotal = lookahead + lookback + dsr * (stagger - 1);
    localparam int aheadSpan = lookahead + dsr * (stagger - 1);
    localparam int backSpan = lookTotal - lookahead;
    localparam int staggerWidth = sampleBits * dsr * stagger;

    // Distributed arithmetic tables
    localparam int lutSize = 4;
    localparam int lutEntries = 2 ** lutSize;
    localparam int lutsPerUnit = lookahead * sampleBits / lutSize;

    // Number formats
    localparam int nMant = 14;
    localparam int coefWidth = nMant + 1;
    localparam int accWidth = 18;
    localparam int outWidth = 12;
    localparam int outShift = 3;
    localparam int scaledWidth = accWidth - outShift;
    localparam int satHeadBits = scaledWidth - outWidth + 1;

    // Enable rates within one evaluation period
    localparam int evalPeriod = dsr * stagger;
    localparam int cntWidth = $clog2(evalPeriod);
    localparam int phaseWidth = $clog2(dsr);

    // Warm-up: window load, LUT read, adder tree and final adder come first
    localparam int validCount = 2;
    localparam int pipeEvals = 4;
    localparam int warmPhases = stagger * pipeEvals + validCount - 1;
    localparam int warmWidth = $clog2(warmPhases + 1);

endpackage

`default_nettype wire
